/* source/lsu_arch_pkg.sv */
`default_nettype none

// MIPS-style architectural constants shared by the load/store path
package lsu_arch_pkg;

    // data and address width
    localparam int xlen = 32;

    // exception codes as in Cause.ExcCode
    typedef logic [4:0] excode_t;

    localparam excode_t exc_adel = 5'd4; // address error on load
    localparam excode_t exc_ades = 5'd5; // address error on store

    // drops segment bits and the byte offset to give the physical address
    localparam logic [xlen-1:0] phys_mask = 32'h1fff_fffc;

    // top three address bits of the uncached kseg1
    localparam logic [2:0] uncached_seg = 3'b101;

    // bus transfer size
    typedef logic [1:0] size_t;

    localparam size_t size_byte = 2'd0;
    localparam size_t size_half = 2'd1;
    localparam size_t size_word = 2'd2;

endpackage

`default_nettype wire

/* source/lsu_pkg.sv */
`default_nettype none

// types private to the load/store unit
package lsu_pkg;

    localparam int reg_idx_w = 5;
    localparam int lane_w    = 4;

    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [lane_w-1:0]    lanes_t;

    // memory ops with loads first
    typedef enum logic [2:0] {
        lb,
        lbu,
        lh,
        lhu,
        lw,
        sb,
        sh,
        sw
    } mem_op_e;

    // what writeback needs to know about an accepted op
    typedef struct packed {
        logic     is_load;
        logic     sign_ext;
        lanes_t   lanes;    // unshifted lane vector
        logic [1:0] offset; // byte offset in the word
        reg_idx_t wreg;
    } pend_rec_t;

endpackage

`default_nettype wire

/* source/lsu_pend_if.sv */
`timescale 1ns/100ps
`default_nettype none

// accepted ops from issue into the writeback queue
interface lsu_pend_if;

    logic              push; // one per address-phase acceptance
    lsu_pkg::pend_rec_t rec;
    logic              full; // already accounts for a pop this cycle

    modport issue (
        output push,
        output rec,
        input  full
    );

    modport wb (
        input  push,
        input  rec,
        output full
    );

endinterface

`default_nettype wire

/* source/lsu_fault_if.sv */
`timescale 1ns/100ps
`default_nettype none

// address error report and the resulting block
interface lsu_fault_if (
    input logic aclk
);

    logic                              raise;
    lsu_arch_pkg::excode_t             code;
    logic [lsu_arch_pkg::xlen-1:0]     badvaddr;
    logic                              blocked;

    modport issue (input aclk, output raise, output code, output badvaddr, input blocked);

    modport regs (input raise, input code, input badvaddr, output blocked);

endinterface

`default_nettype wire

/* source/lsu_issue.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_issue (
    input  logic                          cmd_valid,
    input  lsu_pkg::mem_op_e              cmd_op,
    input  logic [lsu_arch_pkg::xlen-1:0] cmd_addr,
    input  logic [lsu_arch_pkg::xlen-1:0] cmd_wdata,
    input  lsu_pkg::reg_idx_t             cmd_wreg,
    output logic                          cmd_ready,

    output logic                          data_req,
    output logic                          data_wr,
    output logic                          data_cache,
    output lsu_pkg::lanes_t               data_wstrb,
    output logic [lsu_arch_pkg::xlen-1:0] data_addr,
    output lsu_arch_pkg::size_t           data_size,
    output logic [lsu_arch_pkg::xlen-1:0] data_wdata,
    input  logic                          data_addr_ok,

    lsu_pend_if.issue                     pend,
    lsu_fault_if.issue                    fault
);

    logic                          is_load;
    logic                          sign_ext;
    lsu_pkg::lanes_t               lanes;
    lsu_arch_pkg::size_t           size;
    logic [1:0]                    offset;
    logic                          misaligned;
    logic [lsu_arch_pkg::xlen-1:0] wdata_lanes;

    assign offset = cmd_addr[1:0];

    always_comb begin
        is_load  = 1'b0;
        sign_ext = 1'b0;
        lanes    = 4'b0000;
        size     = lsu_arch_pkg::size_byte;
        case (cmd_op)
            lsu_pkg::lb: begin
                is_load  = 1'b1;
                sign_ext = 1'b1;
                lanes    = 4'b0001;
            end
            lsu_pkg::lbu: begin
                is_load = 1'b1;
                lanes   = 4'b0001;
            end
            lsu_pkg::lh: begin
                is_load  = 1'b1;
                sign_ext = 1'b1;
                lanes    = 4'b0011;
                size     = lsu_arch_pkg::size_half;
            end
            lsu_pkg::lhu: begin
                is_load = 1'b1;
                lanes   = 4'b0011;
                size    = lsu_arch_pkg::size_half;
            end
            lsu_pkg::lw: begin
                is_load = 1'b1;
                lanes   = 4'b1111;
                size    = lsu_arch_pkg::size_word;
            end
            lsu_pkg::sb: lanes = 4'b0001;
            lsu_pkg::sh: begin
                lanes = 4'b0011;
                size  = lsu_arch_pkg::size_half;
            end
            lsu_pkg::sw: begin
                lanes = 4'b1111;
                size  = lsu_arch_pkg::size_word;
            end
            default: lanes = 4'b0000;
        endcase
    end

    // half needs bit 0 clear and word needs both
    assign misaligned = (size == lsu_arch_pkg::size_half && offset[0]) ||
                        (size == lsu_arch_pkg::size_word && offset != 2'b00);

    // request only for legal ops with room in the queue
    assign data_req  = cmd_valid && !misaligned && !fault.blocked && !pend.full;
    // a bad op is consumed at once and never reaches the bus
    assign cmd_ready = cmd_valid && !fault.blocked &&
                       (misaligned || (data_req && data_addr_ok));

    assign data_wr    = !is_load;
    assign data_cache = cmd_addr[31:29] != lsu_arch_pkg::uncached_seg; // kseg1 bypasses cache
    assign data_addr  = cmd_addr & lsu_arch_pkg::phys_mask;
    assign data_size  = size;
    assign data_wstrb = is_load ? 4'b0000 : lanes << offset;

    assign wdata_lanes = {{8{lanes[3]}} & cmd_wdata[31:24],
                          {8{lanes[2]}} & cmd_wdata[23:16],
                          {8{lanes[1]}} & cmd_wdata[15:8],
                          {8{lanes[0]}} & cmd_wdata[7:0]};
    assign data_wdata  = wdata_lanes << {offset, 3'b000};

    assign pend.push = data_req && data_addr_ok;
    assign pend.rec  = '{is_load: is_load, sign_ext: sign_ext, lanes: lanes,
                         offset: offset, wreg: cmd_wreg};

    assign fault.raise    = cmd_valid && misaligned && !fault.blocked;
    assign fault.code     = is_load ? lsu_arch_pkg::exc_adel : lsu_arch_pkg::exc_ades;
    assign fault.badvaddr = cmd_addr;

    // alignment rules taken straight from the op
    a_no_misaligned_req: assert property (@(posedge fault.aclk)
        data_req |-> !((cmd_op inside {lsu_pkg::lh, lsu_pkg::lhu, lsu_pkg::sh} && cmd_addr[0]) ||
                       (cmd_op inside {lsu_pkg::lw, lsu_pkg::sw} && cmd_addr[1:0] != 2'b00)));

endmodule

`default_nettype wire

/* source/lsu_fault_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_fault_regs (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          fault_clear,

    lsu_fault_if.regs                     fault,

    output logic                          fault_pending,
    output lsu_arch_pkg::excode_t         fault_excode,
    output logic [lsu_arch_pkg::xlen-1:0] fault_badvaddr
);

    logic                          exl;       // exception level
    lsu_arch_pkg::excode_t         excode_q;
    logic [lsu_arch_pkg::xlen-1:0] badvaddr_q;

    // raise wins over a clear in the same cycle
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            exl <= 1'b0;
        end else if (fault.raise) begin
            exl <= 1'b1;
        end else if (fault_clear) begin
            exl <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (fault.raise) begin
            excode_q   <= fault.code;
            badvaddr_q <= fault.badvaddr;
        end
    end

    // stalls issue until software clears it
    assign fault.blocked = exl;

    assign fault_pending  = exl;
    assign fault_excode   = excode_q;
    assign fault_badvaddr = badvaddr_q;

    // issue must stop raising once blocked
    a_no_nested_raise: assert property (@(posedge aclk) disable iff (!aresetn)
        exl |-> !fault.raise);

endmodule

`default_nettype wire

/* source/lsu_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_writeback #(
    parameter int pend_depth = 2
) (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          data_data_ok,
    input  logic [lsu_arch_pkg::xlen-1:0] data_rdata,

    lsu_pend_if.wb                        pend,

    output logic                          wb_wen,
    output lsu_pkg::reg_idx_t             wb_wnum,
    output logic [lsu_arch_pkg::xlen-1:0] wb_wdata
);

    localparam int ptr_w = pend_depth > 1 ? $clog2(pend_depth) : 1;
    localparam int cnt_w = $clog2(pend_depth + 1);

    lsu_pkg::pend_rec_t            queue [pend_depth];
    logic [ptr_w-1:0]              wr_ptr;
    logic [ptr_w-1:0]              rd_ptr;
    logic [cnt_w-1:0]              count;
    lsu_pkg::pend_rec_t            head;
    logic [lsu_arch_pkg::xlen-1:0] shifted;
    logic [lsu_arch_pkg::xlen-1:0] load_data;
    logic                          ext_b;
    logic                          ext_h;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        logic [ptr_w-1:0] last;
        last = ptr_w'(pend_depth - 1);
        ptr_inc = (p == last) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (pend.push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (data_data_ok)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count + cnt_w'(pend.push) - cnt_w'(data_data_ok);
        end
    end

    always_ff @(posedge aclk) begin
        if (pend.push)
            queue[wr_ptr] <= pend.rec;
    end

    // a return this cycle frees the slot the new push needs
    assign pend.full = (count == cnt_w'(pend_depth)) && !data_data_ok;

    assign head    = queue[rd_ptr];
    assign shifted = data_rdata >> {head.offset, 3'b000};

    // extension bits for byte and half loads
    assign ext_b = head.sign_ext && shifted[7];
    assign ext_h = head.sign_ext && shifted[15];

    always_comb begin
        load_data[7:0]   = {8{head.lanes[0]}} & shifted[7:0];
        load_data[15:8]  = head.lanes[1] ? shifted[15:8] : {8{head.lanes[0] && ext_b}};
        if (head.lanes[3]) begin
            load_data[31:16] = shifted[31:16];
        end else if (head.lanes[1]) begin
            load_data[31:16] = {16{ext_h}};
        end else begin
            load_data[31:16] = {16{head.lanes[0] && ext_b}};
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn)
            wb_wen <= 1'b0;
        else
            wb_wen <= data_data_ok && head.is_load; // stores retire silently
    end

    always_ff @(posedge aclk) begin
        if (data_data_ok) begin
            wb_wnum  <= head.wreg;
            wb_wdata <= load_data;
        end
    end

    a_no_orphan_data: assert property (@(posedge aclk) disable iff (!aresetn)
        data_data_ok |-> count != '0);

endmodule

`default_nettype wire

/* source/lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
    parameter int pend_depth = 2
) (
    input  logic                          aclk,
    input  logic                          aresetn,

    input  logic                          cmd_valid,
    input  lsu_pkg::mem_op_e              cmd_op,
    input  logic [lsu_arch_pkg::xlen-1:0] cmd_addr,
    input  logic [lsu_arch_pkg::xlen-1:0] cmd_wdata,
    input  lsu_pkg::reg_idx_t             cmd_wreg,
    output logic                          cmd_ready,

    output logic                          data_req,
    output logic                          data_wr,
    output logic                          data_cache,
    output lsu_pkg::lanes_t               data_wstrb,
    output logic [lsu_arch_pkg::xlen-1:0] data_addr,
    output lsu_arch_pkg::size_t           data_size,
    output logic [lsu_arch_pkg::xlen-1:0] data_wdata,
    input  logic [lsu_arch_pkg::xlen-1:0] data_rdata,
    input  logic                          data_addr_ok,
    input  logic                          data_data_ok,

    output logic                          wb_wen,
    output lsu_pkg::reg_idx_t             wb_wnum,
    output logic [lsu_arch_pkg::xlen-1:0] wb_wdata,

    input  logic                          fault_clear,
    output logic                          fault_pending,
    output lsu_arch_pkg::excode_t         fault_excode,
    output logic [lsu_arch_pkg::xlen-1:0] fault_badvaddr
);

    lsu_pend_if  u_pend_if ();
    lsu_fault_if u_fault_if (.aclk(aclk));

    lsu_issue u_issue (
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .cmd_wreg     (cmd_wreg),
        .cmd_ready    (cmd_ready),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_cache   (data_cache),
        .data_wstrb   (data_wstrb),
        .data_addr    (data_addr),
        .data_size    (data_size),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok),
        .pend         (u_pend_if.issue),
        .fault        (u_fault_if.issue)
    );

    lsu_fault_regs u_fault_regs (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .fault_clear    (fault_clear),
        .fault          (u_fault_if.regs),
        .fault_pending  (fault_pending),
        .fault_excode   (fault_excode),
        .fault_badvaddr (fault_badvaddr)
    );

    lsu_writeback #(
        .pend_depth (pend_depth)
    ) u_writeback (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata),
        .pend         (u_pend_if.wb),
        .wb_wen       (wb_wen),
        .wb_wnum      (wb_wnum),
        .wb_wdata     (wb_wdata)
    );

endmodule

`default_nettype wire

/* verification/lsu_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

// word memory on the split address/data bus with in-order returns
module lsu_mem_model #(
    parameter int words = 64
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        data_req,
    input  logic        data_wr,
    input  logic [3:0]  data_wstrb,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    output logic        data_addr_ok,
    output logic        data_data_ok,
    output logic [31:0] data_rdata
);

    logic [31:0] mem [words];
    logic [31:0] rng;
    logic [1:0]  wait_cnt; // address phase delay of 0 to 3 cycles
    logic [5:0]  idx;
    logic [31:0] rdata_q [$];
    int          lat_q [$];

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        for (int i = 0; i < words; i++)
            mem[i] = 32'hdead_0000 | 32'(i);
    end

    assign idx          = data_addr[7:2];
    assign data_addr_ok = data_req && wait_cnt == 2'd0;

    always @(posedge aclk) begin
        if (!aresetn) begin
            rng          <= 32'h3aa0;
            wait_cnt     <= 2'd0;
            data_data_ok <= 1'b0;
            data_rdata   <= '0;
            rdata_q.delete();
            lat_q.delete();
        end else begin
            rng          <= xorshift(rng);
            data_data_ok <= 1'b0;
            // oldest entry first so returns stay in order
            if (lat_q.size() > 0) begin
                if (lat_q[0] <= 1) begin
                    data_data_ok <= 1'b1;
                    data_rdata   <= rdata_q.pop_front();
                    void'(lat_q.pop_front());
                end else begin
                    lat_q[0] = lat_q[0] - 1;
                end
            end
            if (data_req && data_addr_ok) begin
                wait_cnt <= rng[1:0];
                lat_q.push_back(int'(rng[3:2]) % 3 + 1);
                rdata_q.push_back(mem[idx]);
                if (data_wr) begin
                    for (int b = 0; b < 4; b++)
                        if (data_wstrb[b])
                            mem[idx][8*b +: 8] <= data_wdata[8*b +: 8];
                end
            end else if (data_req && wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/lsu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;

    typedef struct packed {
        lsu_pkg::mem_op_e op;
        logic [31:0]      addr;
        logic [31:0]      wdata;
        logic [4:0]       wreg;
        logic [31:0]      exp;   // load result or fault code
        logic             fault;
    } row_t;

    logic        aclk = 1'b0;
    logic        aresetn;
    logic        cmd_valid;
    lsu_pkg::mem_op_e cmd_op;
    logic [31:0] cmd_addr;
    logic [31:0] cmd_wdata;
    logic [4:0]  cmd_wreg;
    logic        cmd_ready;
    logic        data_req;
    logic        data_wr;
    logic        data_cache;
    logic [3:0]  data_wstrb;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;
    logic [1:0]  data_size;
    logic        data_addr_ok;
    logic        data_data_ok;
    logic        wb_wen;
    logic [4:0]  wb_wnum;
    logic [31:0] wb_wdata;
    logic        fault_clear;
    logic        fault_pending;
    logic [4:0]  fault_excode;
    logic [31:0] fault_badvaddr;

    row_t        rows [$];
    logic [36:0] exp_q [$]; // {wreg, data} per accepted load
    int          value_errors = 0;
    int          other_errors = 0;

    always #10 aclk = ~aclk;

    lsu_top #(.pend_depth(2)) DUT (.*);

    lsu_mem_model u_mem (
        .aclk(aclk), .aresetn(aresetn), .data_req(data_req), .data_wr(data_wr),
        .data_wstrb(data_wstrb), .data_addr(data_addr), .data_wdata(data_wdata),
        .data_addr_ok(data_addr_ok), .data_data_ok(data_data_ok), .data_rdata(data_rdata)
    );

    task automatic add_row(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [4:0] wreg,
                           input logic [31:0] exp, input logic fault);
        rows.push_back(row_t'{op, addr, wdata, wreg, exp, fault});
    endtask

    task automatic value_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        value_errors++;
    endtask

    task automatic other_error(input string msg);
        $display("at %0t: %s", $time, msg);
        other_errors++;
    endtask

    // bus fields of a legal command from the MIPS access rules
    task automatic check_bus(input row_t r);
        logic [1:0]  size;
        logic [3:0]  lanes;
        logic [31:0] mask;
        logic        is_store;
        size     = (r.op inside {lsu_pkg::lb, lsu_pkg::lbu, lsu_pkg::sb}) ? 2'd0 :
                   (r.op inside {lsu_pkg::lh, lsu_pkg::lhu, lsu_pkg::sh}) ? 2'd1 : 2'd2;
        lanes    = size == 2'd0 ? 4'b0001 : size == 2'd1 ? 4'b0011 : 4'b1111;
        mask     = size == 2'd0 ? 32'hff : size == 2'd1 ? 32'hffff : 32'hffff_ffff;
        is_store = r.op inside {lsu_pkg::sb, lsu_pkg::sh, lsu_pkg::sw};
        if (data_size != size)
            value_error($sformatf("data_size %0d, expected %0d", data_size, size));
        if (data_addr != (r.addr & 32'h1fff_fffc))
            value_error($sformatf("data_addr %h for address %h", data_addr, r.addr));
        if (data_cache != (r.addr[31:29] != 3'b101))
            value_error($sformatf("data_cache %b for address %h", data_cache, r.addr));
        if (data_wr != is_store)
            value_error($sformatf("data_wr %b", data_wr));
        if (is_store && data_wstrb != 4'(lanes << r.addr[1:0]))
            value_error($sformatf("data_wstrb %b for address %h", data_wstrb, r.addr));
        if (is_store && data_wdata != ((r.wdata & mask) << (8 * r.addr[1:0])))
            value_error($sformatf("data_wdata %h for store data %h", data_wdata, r.wdata));
    endtask

    // register writes are checked in command order
    always @(negedge aclk) begin
        logic [36:0] e;
        if (aresetn === 1'b1 && wb_wen) begin
            if (exp_q.size() == 0) begin
                other_error("register write with no load outstanding");
            end else begin
                e = exp_q.pop_front();
                if (wb_wnum != e[36:32] || wb_wdata != e[31:0])
                    value_error($sformatf("write r%0d=%h, expected r%0d=%h",
                                          wb_wnum, wb_wdata, e[36:32], e[31:0]));
            end
        end
    end

    initial begin
        int limit;
        #1;
        limit = rows.size() * 20 + 50;
        repeat (limit) @(posedge aclk);
        $display("watchdog expired after %0d cycles, the run did not finish", limit);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        row_t r;
        logic accepted;
        // stores at every legal offset and in both segments
        add_row(lsu_pkg::sw,  32'h8000_0010, 32'h8765_4321, 5'd0,  32'h0, 1'b0);
        add_row(lsu_pkg::sb,  32'ha000_0014, 32'h0000_00f0, 5'd0,  32'h0, 1'b0);
        add_row(lsu_pkg::sb,  32'h8000_0015, 32'h0000_007f, 5'd0,  32'h0, 1'b0);
        add_row(lsu_pkg::sb,  32'ha000_0016, 32'h0000_0080, 5'd0,  32'h0, 1'b0);
        add_row(lsu_pkg::sb,  32'h8000_0017, 32'h0000_0001, 5'd0,  32'h0, 1'b0);
        add_row(lsu_pkg::sh,  32'h8000_0018, 32'h1234_8001, 5'd0,  32'h0, 1'b0);
        add_row(lsu_pkg::sh,  32'ha000_001a, 32'h0000_7ffe, 5'd0,  32'h0, 1'b0);
        // back-to-back loads of what was just written
        add_row(lsu_pkg::lw,  32'h8000_0010, 32'h0, 5'd1,  32'h8765_4321, 1'b0);
        add_row(lsu_pkg::lb,  32'h8000_0014, 32'h0, 5'd2,  32'hffff_fff0, 1'b0);
        add_row(lsu_pkg::lbu, 32'h8000_0014, 32'h0, 5'd3,  32'h0000_00f0, 1'b0);
        add_row(lsu_pkg::lb,  32'ha000_0015, 32'h0, 5'd4,  32'h0000_007f, 1'b0);
        add_row(lsu_pkg::lb,  32'h8000_0016, 32'h0, 5'd5,  32'hffff_ff80, 1'b0);
        add_row(lsu_pkg::lbu, 32'h8000_0016, 32'h0, 5'd6,  32'h0000_0080, 1'b0);
        add_row(lsu_pkg::lb,  32'h8000_0017, 32'h0, 5'd7,  32'h0000_0001, 1'b0);
        add_row(lsu_pkg::lh,  32'h8000_0018, 32'h0, 5'd8,  32'hffff_8001, 1'b0);
        add_row(lsu_pkg::lhu, 32'h8000_0018, 32'h0, 5'd9,  32'h0000_8001, 1'b0);
        add_row(lsu_pkg::lh,  32'h8000_001a, 32'h0, 5'd10, 32'h0000_7ffe, 1'b0);
        add_row(lsu_pkg::lhu, 32'h8000_0012, 32'h0, 5'd11, 32'h0000_8765, 1'b0);
        // misaligned ops raise AdEL = 4 or AdES = 5
        add_row(lsu_pkg::lh,  32'h8000_0011, 32'h0, 5'd12, 32'd4, 1'b1);
        add_row(lsu_pkg::sw,  32'h8000_0012, 32'h5, 5'd0,  32'd5, 1'b1);
        add_row(lsu_pkg::lw,  32'h8000_0013, 32'h0, 5'd13, 32'd4, 1'b1);
        add_row(lsu_pkg::sh,  32'h8000_0019, 32'h6, 5'd0,  32'd5, 1'b1);
        add_row(lsu_pkg::lw,  32'h8000_0018, 32'h0, 5'd14, 32'h7ffe_8001, 1'b0);
        add_row(lsu_pkg::lw,  32'h8000_0014, 32'h0, 5'd15, 32'h0180_7ff0, 1'b0);

        aresetn     = 1'b0;
        cmd_valid   = 1'b0;
        cmd_op      = lsu_pkg::lw;
        cmd_addr    = '0;
        cmd_wdata   = '0;
        cmd_wreg    = '0;
        fault_clear = 1'b0;
        repeat (7) @(posedge aclk);
        @(negedge aclk);
        if (data_req || cmd_ready || wb_wen || fault_pending)
            value_error("outputs not low in reset");
        @(posedge aclk);
        #2 aresetn = 1'b1;

        foreach (rows[i]) begin
            r = rows[i];
            @(posedge aclk);
            #2;
            cmd_valid = 1'b1;
            cmd_op    = r.op;
            cmd_addr  = r.addr;
            cmd_wdata = r.wdata;
            cmd_wreg  = r.wreg;
            if (r.fault) begin
                @(negedge aclk);
                if (data_req)
                    value_error($sformatf("data_req for misaligned %h", r.addr));
                if (!cmd_ready)
                    other_error("misaligned command was not taken in its first cycle");
                @(posedge aclk);
                #2 cmd_valid = 1'b0;
                @(negedge aclk);
                if (!fault_pending || fault_excode != r.exp[4:0] || fault_badvaddr != r.addr)
                    value_error($sformatf("fault %b code %0d badvaddr %h",
                                          fault_pending, fault_excode, fault_badvaddr));
                // a legal command must wait while the fault is pending
                @(posedge aclk);
                #2;
                cmd_valid = 1'b1;
                cmd_op    = lsu_pkg::lw;
                cmd_addr  = 32'h8000_0000;
                repeat (3) begin
                    @(negedge aclk);
                    if (cmd_ready || data_req)
                        other_error("command went out while a fault was pending");
                end
                @(posedge aclk);
                #2;
                cmd_valid   = 1'b0;
                fault_clear = 1'b1;
                @(posedge aclk);
                #2 fault_clear = 1'b0;
                @(negedge aclk);
                if (fault_pending)
                    value_error("fault_pending still high after fault_clear");
            end else begin
                accepted = 1'b0;
                while (!accepted) begin
                    @(negedge aclk);
                    if (data_req)
                        check_bus(r);
                    if (cmd_ready) begin
                        accepted = 1'b1;
                        if (!data_req)
                            other_error("legal command taken without a bus request");
                        if (r.op inside {lsu_pkg::lb, lsu_pkg::lbu, lsu_pkg::lh,
                                         lsu_pkg::lhu, lsu_pkg::lw})
                            exp_q.push_back({r.wreg, r.exp});
                    end
                end
            end
        end
        @(posedge aclk);
        #2 cmd_valid = 1'b0;
        while (exp_q.size() > 0)
            @(posedge aclk);
        repeat (4) @(posedge aclk);

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/lsu_arch_pkg.sv
source/lsu_pkg.sv
source/lsu_pend_if.sv
source/lsu_fault_if.sv
source/lsu_issue.sv
source/lsu_fault_regs.sv
source/lsu_writeback.sv
source/lsu_top.sv
verification/lsu_mem_model.sv
verification/lsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= lsu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
